/* source/debug_pkg.sv */
package debug_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // host address ports, only the low bits reach the memory
    localparam int ROM_ADDR_W  = 24;
    localparam int ROM_DEPTH_W = 10;
    localparam int DATA_W      = 8;
    // command byte on top, data byte below
    localparam int INFO_W      = 16;
    localparam int REG_COUNT   = 4;

    ////////////////////////////////////////
    // host commands
    ////////////////////////////////////////

    typedef enum logic [7:0] {
        free_run   = 8'd0,
        debug      = 8'd1,
        clear_addr = 8'd2,
        clear_data = 8'd3,
        read_rom   = 8'd4,
        write_rom  = 8'd5,
        read_a     = 8'd6,
        read_b     = 8'd7,
        read_c     = 8'd8,
        read_d     = 8'd9
    } dbg_cmd_e;

    // instruction bits 7..5
    typedef enum logic [2:0] {
        nop    = 3'd0,
        ldi    = 3'd1,
        mov    = 3'd2,
        add    = 3'd3,
        sub    = 3'd4,
        and_op = 3'd5,
        xor_op = 3'd6,
        inc    = 3'd7
    } cpu_op_e;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        fetch = 2'd1,
        exec  = 2'd2
    } cpu_state_e;

endpackage

/* source/debug_cmd_decode.sv */
`timescale 1ns/10ps

module debug_cmd_decode
(
    input  logic                              clk,
    input  logic                              rst_n,

    // host command link
    input  logic                              recv_en,
    input  logic [debug_pkg::DATA_W-1:0]      recv_cmd,
    input  logic [debug_pkg::DATA_W-1:0]      recv_data,
    output logic                              send_en,
    output logic [debug_pkg::DATA_W-1:0]      send_cmd,
    output logic [debug_pkg::DATA_W-1:0]      send_data,
    input  logic                              send_ready,

    // program memory
    output logic                              rom_wen,
    output logic [debug_pkg::ROM_ADDR_W-1:0]  rom_waddr,
    output logic [debug_pkg::DATA_W-1:0]      rom_wdata,
    output logic                              rom_ren,
    output logic [debug_pkg::ROM_ADDR_W-1:0]  rom_raddr,
    input  logic [debug_pkg::DATA_W-1:0]      rom_rdata,

    // cpu control
    output logic                              dbg_en,
    output logic                              dbg_inst_en,
    output logic [debug_pkg::DATA_W-1:0]      dbg_inst,

    // register reports
    output logic [debug_pkg::REG_COUNT-1:0]   read_abcd,
    input  logic                              dbg_info_en,
    input  logic [debug_pkg::INFO_W-1:0]      dbg_info
);

    logic cmd_free_run;
    logic cmd_debug;
    logic cmd_clear_addr;
    logic cmd_clear_data;
    logic cmd_read_rom;
    logic cmd_write_rom;
    logic rom_ren_d0;
    logic rom_ren_d1;
    logic rom_back_en;

    assign cmd_free_run   = (recv_cmd == debug_pkg::free_run);
    assign cmd_debug      = (recv_cmd == debug_pkg::debug);
    assign cmd_clear_addr = (recv_cmd == debug_pkg::clear_addr);
    assign cmd_clear_data = (recv_cmd == debug_pkg::clear_data);
    assign cmd_read_rom   = (recv_cmd == debug_pkg::read_rom);
    assign cmd_write_rom  = (recv_cmd == debug_pkg::write_rom);

    ////////////////////////////////////////
    // cpu control
    ////////////////////////////////////////

    // mode follows the command level, no strobe needed
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dbg_en      <= 1'b0;
            dbg_inst_en <= 1'b0;
            read_abcd   <= '0;
        end
        else
        begin
            if (cmd_free_run)
                dbg_en <= 1'b0;
            else if (cmd_debug)
                dbg_en <= 1'b1;
            dbg_inst_en  <= recv_en && cmd_debug;
            read_abcd[0] <= recv_en && (recv_cmd == debug_pkg::read_a);
            read_abcd[1] <= recv_en && (recv_cmd == debug_pkg::read_b);
            read_abcd[2] <= recv_en && (recv_cmd == debug_pkg::read_c);
            read_abcd[3] <= recv_en && (recv_cmd == debug_pkg::read_d);
        end
    end

    always_ff @(posedge clk)
    begin
        if (recv_en && cmd_debug)
            dbg_inst <= recv_data;
    end

    ////////////////////////////////////////
    // memory write and read pointers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rom_wen   <= 1'b0;
            rom_ren   <= 1'b0;
            rom_waddr <= '0;
            rom_raddr <= '0;
        end
        else
        begin
            // clear_data keeps writing zeros every cycle
            rom_wen <= cmd_clear_data || (recv_en && cmd_write_rom);
            rom_ren <= recv_en && cmd_read_rom;
            if (cmd_clear_addr)
                rom_waddr <= '0;
            else if (rom_wen)
                rom_waddr <= rom_waddr + 1'b1;
            if (cmd_clear_addr)
                rom_raddr <= '0;
            else if (rom_ren)
                rom_raddr <= rom_raddr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_clear_data)
            rom_wdata <= '0;
        else if (recv_en && cmd_write_rom)
            rom_wdata <= recv_data;
    end

    ////////////////////////////////////////
    // return path to the host
    ////////////////////////////////////////

    // three stages from rom_ren to the returned byte
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rom_ren_d0  <= 1'b0;
            rom_ren_d1  <= 1'b0;
            rom_back_en <= 1'b0;
            send_en     <= 1'b0;
        end
        else
        begin
            rom_ren_d0  <= rom_ren;
            rom_ren_d1  <= rom_ren_d0;
            rom_back_en <= rom_ren_d1;
            // dropped when the host is not ready
            send_en     <= send_ready && (dbg_info_en || rom_back_en);
        end
    end

    // register report wins over a memory byte
    always_ff @(posedge clk)
    begin
        if (dbg_info_en)
        begin
            send_cmd  <= dbg_info[debug_pkg::INFO_W-1:debug_pkg::DATA_W];
            send_data <= dbg_info[debug_pkg::DATA_W-1:0];
        end
        else if (rom_back_en)
        begin
            send_cmd  <= '0;
            send_data <= rom_rdata;
        end
    end

endmodule

/* source/program_rom.sv */
`timescale 1ns/10ps

module program_rom
(
    input  logic                               clk,

    // host write port
    input  logic                               rom_wen,
    input  logic [debug_pkg::ROM_ADDR_W-1:0]   rom_waddr,
    input  logic [debug_pkg::DATA_W-1:0]       rom_wdata,

    // host read port
    input  logic                               rom_ren,
    input  logic [debug_pkg::ROM_ADDR_W-1:0]   rom_raddr,
    output logic [debug_pkg::DATA_W-1:0]       rom_rdata,

    // cpu fetch port
    input  logic [debug_pkg::ROM_DEPTH_W-1:0]  fetch_addr,
    output logic [debug_pkg::DATA_W-1:0]       fetch_data
);

    logic [debug_pkg::DATA_W-1:0] mem [2**debug_pkg::ROM_DEPTH_W];

    always_ff @(posedge clk)
    begin
        if (rom_wen)
            mem[rom_waddr[debug_pkg::ROM_DEPTH_W-1:0]] <= rom_wdata;
    end

    // held until the next host read
    always_ff @(posedge clk)
    begin
        if (rom_ren)
            rom_rdata <= mem[rom_raddr[debug_pkg::ROM_DEPTH_W-1:0]];
    end

    // fetch port reads every cycle
    always_ff @(posedge clk)
    begin
        fetch_data <= mem[fetch_addr];
    end

endmodule

/* source/cpu_execute.sv */
`timescale 1ns/10ps

module cpu_execute
(
    input  logic                               clk,
    input  logic                               rst_n,

    // debug control
    input  logic                               dbg_en,
    input  logic                               dbg_inst_en,
    input  logic [debug_pkg::DATA_W-1:0]       dbg_inst,

    // program memory fetch
    output logic [debug_pkg::ROM_DEPTH_W-1:0]  fetch_addr,
    input  logic [debug_pkg::DATA_W-1:0]       fetch_data,

    // register file
    output logic [debug_pkg::DATA_W-1:0]       reg_a,
    output logic [debug_pkg::DATA_W-1:0]       reg_b,
    output logic [debug_pkg::DATA_W-1:0]       reg_c,
    output logic [debug_pkg::DATA_W-1:0]       reg_d
);

    debug_pkg::cpu_state_e              state;
    debug_pkg::cpu_op_e                 op;
    logic [debug_pkg::ROM_DEPTH_W-1:0]  pc;
    logic [debug_pkg::DATA_W-1:0]       regs [debug_pkg::REG_COUNT];
    logic [debug_pkg::DATA_W-1:0]       inst;
    logic [debug_pkg::DATA_W-1:0]       dst_val;
    logic [debug_pkg::DATA_W-1:0]       src_val;
    logic [debug_pkg::DATA_W-1:0]       alu_out;
    logic [1:0]                         dst_sel;
    logic [1:0]                         src_sel;
    logic                               inst_valid;
    logic                               alu_wen;

    ////////////////////////////////////////
    // instruction select and decode
    ////////////////////////////////////////

    // injected instructions only run while parked in idle
    assign inst_valid = (state == debug_pkg::exec) ||
                        (state == debug_pkg::idle && dbg_inst_en);
    assign inst       = (state == debug_pkg::exec) ? fetch_data : dbg_inst;

    assign op      = debug_pkg::cpu_op_e'(inst[7:5]);
    assign dst_sel = inst[4:3];
    assign src_sel = inst[2:1];
    assign dst_val = regs[dst_sel];
    assign src_val = regs[src_sel];

    ////////////////////////////////////////
    // shared alu
    ////////////////////////////////////////

    always_comb
    begin
        alu_wen = 1'b1;
        case (op)
            debug_pkg::ldi:    alu_out = {{(debug_pkg::DATA_W-3){1'b0}}, inst[2:0]};
            debug_pkg::mov:    alu_out = src_val;
            debug_pkg::add:    alu_out = dst_val + src_val;
            debug_pkg::sub:    alu_out = dst_val - src_val;
            debug_pkg::and_op: alu_out = dst_val & src_val;
            debug_pkg::xor_op: alu_out = dst_val ^ src_val;
            debug_pkg::inc:    alu_out = dst_val + 1'b1;
            default:
            begin
                // nop leaves the registers alone
                alu_out = dst_val;
                alu_wen = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < debug_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (inst_valid && alu_wen)
        begin
            regs[dst_sel] <= alu_out;
        end
    end

    ////////////////////////////////////////
    // fetch / exec sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= debug_pkg::fetch;
            pc    <= '0;
        end
        else
        begin
            case (state)
                debug_pkg::fetch:
                    state <= dbg_en ? debug_pkg::idle : debug_pkg::exec;
                debug_pkg::exec:
                begin
                    pc    <= pc + 1'b1;
                    state <= dbg_en ? debug_pkg::idle : debug_pkg::fetch;
                end
                // resume at the held pc
                debug_pkg::idle:
                    if (!dbg_en)
                        state <= debug_pkg::fetch;
                default:
                    state <= debug_pkg::fetch;
            endcase
        end
    end

    assign fetch_addr = pc;

    assign reg_a = regs[0];
    assign reg_b = regs[1];
    assign reg_c = regs[2];
    assign reg_d = regs[3];

endmodule

/* source/reg_report.sv */
`timescale 1ns/10ps

module reg_report
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [debug_pkg::REG_COUNT-1:0]  read_abcd,
    input  logic [debug_pkg::DATA_W-1:0]     reg_a,
    input  logic [debug_pkg::DATA_W-1:0]     reg_b,
    input  logic [debug_pkg::DATA_W-1:0]     reg_c,
    input  logic [debug_pkg::DATA_W-1:0]     reg_d,
    output logic                             dbg_info_en,
    output logic [debug_pkg::INFO_W-1:0]     dbg_info
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dbg_info_en <= 1'b0;
        else
            dbg_info_en <= |read_abcd;
    end

    // lowest requested register wins
    always_ff @(posedge clk)
    begin
        if (read_abcd[0])
            dbg_info <= {debug_pkg::read_a, reg_a};
        else if (read_abcd[1])
            dbg_info <= {debug_pkg::read_b, reg_b};
        else if (read_abcd[2])
            dbg_info <= {debug_pkg::read_c, reg_c};
        else if (read_abcd[3])
            dbg_info <= {debug_pkg::read_d, reg_d};
    end

endmodule

/* source/debug_system.sv */
`timescale 1ns/10ps

module debug_system
(
    input  logic                          clk,
    input  logic                          rst_n,

    // host link
    input  logic                          recv_en,
    input  logic [debug_pkg::DATA_W-1:0]  recv_cmd,
    input  logic [debug_pkg::DATA_W-1:0]  recv_data,
    output logic                          send_en,
    output logic [debug_pkg::DATA_W-1:0]  send_cmd,
    output logic [debug_pkg::DATA_W-1:0]  send_data,
    input  logic                          send_ready
);

    logic                               rom_wen;
    logic [debug_pkg::ROM_ADDR_W-1:0]   rom_waddr;
    logic [debug_pkg::DATA_W-1:0]       rom_wdata;
    logic                               rom_ren;
    logic [debug_pkg::ROM_ADDR_W-1:0]   rom_raddr;
    logic [debug_pkg::DATA_W-1:0]       rom_rdata;
    logic                               dbg_en;
    logic                               dbg_inst_en;
    logic [debug_pkg::DATA_W-1:0]       dbg_inst;
    logic [debug_pkg::REG_COUNT-1:0]    read_abcd;
    logic                               dbg_info_en;
    logic [debug_pkg::INFO_W-1:0]       dbg_info;
    logic [debug_pkg::ROM_DEPTH_W-1:0]  fetch_addr;
    logic [debug_pkg::DATA_W-1:0]       fetch_data;
    logic [debug_pkg::DATA_W-1:0]       reg_a;
    logic [debug_pkg::DATA_W-1:0]       reg_b;
    logic [debug_pkg::DATA_W-1:0]       reg_c;
    logic [debug_pkg::DATA_W-1:0]       reg_d;

    ////////////////////////////////////////
    // decode stage
    ////////////////////////////////////////

    debug_cmd_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .recv_en     (recv_en),
        .recv_cmd    (recv_cmd),
        .recv_data   (recv_data),
        .send_en     (send_en),
        .send_cmd    (send_cmd),
        .send_data   (send_data),
        .send_ready  (send_ready),
        .rom_wen     (rom_wen),
        .rom_waddr   (rom_waddr),
        .rom_wdata   (rom_wdata),
        .rom_ren     (rom_ren),
        .rom_raddr   (rom_raddr),
        .rom_rdata   (rom_rdata),
        .dbg_en      (dbg_en),
        .dbg_inst_en (dbg_inst_en),
        .dbg_inst    (dbg_inst),
        .read_abcd   (read_abcd),
        .dbg_info_en (dbg_info_en),
        .dbg_info    (dbg_info)
    );

    program_rom u_rom (
        .clk        (clk),
        .rom_wen    (rom_wen),
        .rom_waddr  (rom_waddr),
        .rom_wdata  (rom_wdata),
        .rom_ren    (rom_ren),
        .rom_raddr  (rom_raddr),
        .rom_rdata  (rom_rdata),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    ////////////////////////////////////////
    // execute and result stages
    ////////////////////////////////////////

    cpu_execute u_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbg_en      (dbg_en),
        .dbg_inst_en (dbg_inst_en),
        .dbg_inst    (dbg_inst),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .reg_c       (reg_c),
        .reg_d       (reg_d)
    );

    reg_report u_report (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_abcd   (read_abcd),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .reg_c       (reg_c),
        .reg_d       (reg_d),
        .dbg_info_en (dbg_info_en),
        .dbg_info    (dbg_info)
    );

endmodule

/* tb/debug_system_assertions.sv */
`timescale 1ns/10ps

module debug_system_assertions
(
    input logic                             clk,
    input logic                             rst_n,
    input logic                             send_ready,
    input logic                             send_en,
    input logic                             rom_wen,
    input logic                             rom_ren,
    input logic                             rom_back_en,
    input logic                             dbg_en,
    input logic                             dbg_inst_en,
    input logic [debug_pkg::REG_COUNT-1:0]  read_abcd,
    input logic                             dbg_info_en
);

    int fail_count = 0;

    ////////////////////////////////////////
    // return path
    ////////////////////////////////////////

    ready_gates_send: assert property (
        @(posedge clk) disable iff (!rst_n) !send_ready |=> !send_en)
    else
    begin
        fail_count++;
        $error("send_en rose while send_ready was low");
    end

    // three stage delay from read strobe to return strobe
    return_follows_read: assert property (
        @(posedge clk) disable iff (!rst_n) $past(rom_ren, 3) |-> rom_back_en)
    else
    begin
        fail_count++;
        $error("no return strobe three cycles after rom_ren");
    end

    ////////////////////////////////////////
    // reset values
    ////////////////////////////////////////

    reset_clears_controls: assert property (
        @(posedge clk) !rst_n |=> (!send_en && !rom_wen && !rom_ren && !dbg_en &&
                                   !dbg_inst_en && read_abcd == '0 && !dbg_info_en))
    else
    begin
        fail_count++;
        $error("control outputs not low after reset");
    end

endmodule

bind debug_cmd_decode debug_system_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .send_ready  (send_ready),
    .send_en     (send_en),
    .rom_wen     (rom_wen),
    .rom_ren     (rom_ren),
    .rom_back_en (rom_back_en),
    .dbg_en      (dbg_en),
    .dbg_inst_en (dbg_inst_en),
    .read_abcd   (read_abcd),
    .dbg_info_en (dbg_info_en)
);

/* tb/debug_system_tb.sv */
`timescale 1ns/10ps

module debug_system_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int STEP_COUNT   = 20;
    localparam int ROM_BYTES    = 16;
    localparam int CLEAR_CYCLES = 8;
    localparam int CLEAR_CHECK  = 10;
    localparam int PROG_BYTES   = 32;
    localparam int RUN_CYCLES   = 40;
    // rough length of each test in cycles, watchdog allows four times the sum
    localparam int TEST_CYCLES  = RESET_CYCLES + 60 + 200 + 120 + 150 + 40;
    localparam int WATCHDOG_NS  = TEST_CYCLES * 4 * CLK_PERIOD;

    typedef struct packed {
        logic                                is_rom;
        debug_pkg::dbg_cmd_e                 cmd;
        logic [debug_pkg::DATA_W-1:0]        val;
        int                                  index;
    } expect_t;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    recv_en;
    logic [debug_pkg::DATA_W-1:0]            recv_cmd;
    logic [debug_pkg::DATA_W-1:0]            recv_data;
    logic                                    send_en;
    logic [debug_pkg::DATA_W-1:0]            send_cmd;
    logic [debug_pkg::DATA_W-1:0]            send_data;
    logic                                    send_ready;

    integer                                  seed;
    expect_t                                 exp_q [$];
    expect_t                                 cur_exp;
    logic [debug_pkg::DATA_W-1:0]            model_regs [debug_pkg::REG_COUNT];
    logic [debug_pkg::DATA_W-1:0]            rom_bytes [ROM_BYTES];
    string                                   cur_test;
    int                                      error_count;
    int                                      errors_at_start;
    int                                      tests_run;
    int                                      tests_failed;
    int                                      total_errors;

    debug_system uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .recv_en    (recv_en),
        .recv_cmd   (recv_cmd),
        .recv_data  (recv_data),
        .send_en    (send_en),
        .send_cmd   (send_cmd),
        .send_data  (send_data),
        .send_ready (send_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [7:0] ref_alu(input logic [7:0] inst, input logic [7:0] dst_val,
                                           input logic [7:0] src_val);
        debug_pkg::cpu_op_e op;
        op = debug_pkg::cpu_op_e'(inst[7:5]);
        case (op)
            debug_pkg::ldi:    return {5'd0, inst[2:0]};
            debug_pkg::mov:    return src_val;
            debug_pkg::add:    return dst_val + src_val;
            debug_pkg::sub:    return dst_val - src_val;
            debug_pkg::and_op: return dst_val & src_val;
            debug_pkg::xor_op: return dst_val ^ src_val;
            debug_pkg::inc:    return dst_val + 8'd1;
            default:           return dst_val;
        endcase
    endfunction

    // nop hands back the old value, so the write is harmless
    task automatic model_step(input logic [7:0] inst);
        model_regs[inst[4:3]] = ref_alu(inst, model_regs[inst[4:3]], model_regs[inst[2:1]]);
    endtask

    function automatic logic [7:0] encode_op(input debug_pkg::cpu_op_e op,
                                             input logic [1:0] dst, input logic [1:0] src);
        return {op, dst, src, 1'b0};
    endfunction

    function automatic logic [7:0] encode_ldi(input logic [1:0] dst, input logic [2:0] imm);
        return {debug_pkg::ldi, dst, imm};
    endfunction

    function automatic debug_pkg::dbg_cmd_e read_cmd_for(input int r);
        case (r)
            0:       return debug_pkg::read_a;
            1:       return debug_pkg::read_b;
            2:       return debug_pkg::read_c;
            default: return debug_pkg::read_d;
        endcase
    endfunction

    ////////////////////////////////////////
    // host side drive
    ////////////////////////////////////////

    // read_rom without recv_en does nothing, a safe resting level
    task automatic host_send(input debug_pkg::dbg_cmd_e cmd, input logic [7:0] data);
        @(posedge clk);
        recv_en   <= 1'b1;
        recv_cmd  <= cmd;
        recv_data <= data;
        @(posedge clk);
        recv_en  <= 1'b0;
        recv_cmd <= debug_pkg::read_rom;
    endtask

    // level commands act on every sampled cycle
    task automatic hold_level(input debug_pkg::dbg_cmd_e cmd, input int cycles);
        @(posedge clk);
        recv_cmd <= cmd;
        repeat (cycles) @(posedge clk);
        recv_cmd <= debug_pkg::read_rom;
    endtask

    task automatic expect_report(input debug_pkg::dbg_cmd_e cmd, input logic [7:0] val);
        exp_q.push_back('{is_rom: 1'b0, cmd: cmd, val: val, index: 0});
    endtask

    task automatic expect_rom(input int index, input logic [7:0] val);
        exp_q.push_back('{is_rom: 1'b1, cmd: debug_pkg::free_run, val: val, index: index});
    endtask

    task automatic wait_responses(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles)
        begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("error in %s: %0d responses never arrived within %0d cycles",
                     cur_test, exp_q.size(), max_cycles);
            error_count++;
            exp_q.delete();
        end
    endtask

    ////////////////////////////////////////
    // compare
    ////////////////////////////////////////

    task automatic check_report(input debug_pkg::dbg_cmd_e exp_cmd,
                                input logic [debug_pkg::DATA_W-1:0] exp_val,
                                input logic [debug_pkg::DATA_W-1:0] act_cmd,
                                input logic [debug_pkg::DATA_W-1:0] act_val);
        if (act_cmd !== exp_cmd || act_val !== exp_val)
        begin
            $display("mismatch %s: expected cmd %02h data %02h, actual cmd %02h data %02h",
                     cur_test, exp_cmd, exp_val, act_cmd, act_val);
            error_count++;
        end
    endtask

    // memory returns always carry command byte 0
    task automatic check_rom_byte(input int index, input logic [debug_pkg::DATA_W-1:0] exp_val,
                                  input logic [debug_pkg::DATA_W-1:0] act_cmd,
                                  input logic [debug_pkg::DATA_W-1:0] act_val);
        if (act_cmd !== 8'h00 || act_val !== exp_val)
        begin
            $display("mismatch %s: byte %0d expected cmd 00 data %02h, actual cmd %02h data %02h",
                     cur_test, index, exp_val, act_cmd, act_val);
            error_count++;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst_n && send_en)
        begin
            if (exp_q.size() == 0)
            begin
                $display("error in %s: send_en with nothing expected, cmd %02h data %02h",
                         cur_test, send_cmd, send_data);
                error_count++;
            end
            else
            begin
                cur_exp = exp_q.pop_front();
                if (cur_exp.is_rom)
                    check_rom_byte(cur_exp.index, cur_exp.val, send_cmd, send_data);
                else
                    check_report(cur_exp.cmd, cur_exp.val, send_cmd, send_data);
            end
        end
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start)
        begin
            $display("test %s: ok", cur_test);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, error_count - errors_at_start);
        end
    endtask

    task automatic read_registers();
        for (int r = 0; r < debug_pkg::REG_COUNT; r++)
        begin
            expect_report(read_cmd_for(r), model_regs[r]);
            host_send(read_cmd_for(r), 8'h00);
        end
        wait_responses(20);
    endtask

    task automatic debug_stepping();
        logic [7:0] inst;
        begin_test("debug_stepping");
        host_send(debug_pkg::debug, 8'h00);
        repeat (4) @(posedge clk);
        // load every register first
        for (int r = 0; r < debug_pkg::REG_COUNT; r++)
        begin
            inst = encode_ldi(2'(r), 3'($random(seed)));
            host_send(debug_pkg::debug, inst);
            model_step(inst);
        end
        for (int i = debug_pkg::REG_COUNT; i < STEP_COUNT; i++)
        begin
            inst = 8'($random(seed));
            host_send(debug_pkg::debug, inst);
            model_step(inst);
        end
        read_registers();
        finish_test();
    endtask

    task automatic rom_round_trip();
        begin_test("rom_round_trip");
        host_send(debug_pkg::clear_addr, 8'h00);
        for (int i = 0; i < ROM_BYTES; i++)
        begin
            rom_bytes[i] = 8'($random(seed));
            host_send(debug_pkg::write_rom, rom_bytes[i]);
        end
        host_send(debug_pkg::clear_addr, 8'h00);
        // held read data would be overwritten by a following read, so one at a time
        for (int i = 0; i < ROM_BYTES; i++)
        begin
            expect_rom(i, rom_bytes[i]);
            host_send(debug_pkg::read_rom, 8'h00);
            wait_responses(12);
        end
        finish_test();
    endtask

    task automatic clear_data_fill();
        begin_test("clear_data_fill");
        host_send(debug_pkg::clear_addr, 8'h00);
        hold_level(debug_pkg::clear_data, CLEAR_CYCLES);
        repeat (2) @(posedge clk);
        host_send(debug_pkg::clear_addr, 8'h00);
        for (int i = 0; i < CLEAR_CHECK; i++)
        begin
            expect_rom(i, (i < CLEAR_CYCLES) ? 8'h00 : rom_bytes[i]);
            host_send(debug_pkg::read_rom, 8'h00);
            wait_responses(12);
        end
        finish_test();
    endtask

    task automatic free_run_program();
        logic [7:0] prog [PROG_BYTES];
        begin_test("free_run_program");
        for (int i = 0; i < PROG_BYTES; i++)
            prog[i] = encode_op(debug_pkg::nop, 2'd0, 2'd0);
        // lead-in nops cover wherever the held pc sits
        prog[4]  = encode_ldi(2'd0, 3'($random(seed)));
        prog[5]  = encode_ldi(2'd1, 3'($random(seed)));
        prog[6]  = encode_op(debug_pkg::add, 2'd0, 2'd1);
        prog[7]  = encode_op(debug_pkg::inc, 2'd2, 2'd0);
        prog[8]  = encode_op(debug_pkg::add, 2'd2, 2'd0);
        prog[9]  = encode_op(debug_pkg::inc, 2'd3, 2'd0);
        prog[10] = encode_op(debug_pkg::add, 2'd3, 2'd3);
        prog[11] = encode_op(debug_pkg::inc, 2'd1, 2'd0);
        host_send(debug_pkg::clear_addr, 8'h00);
        for (int i = 0; i < PROG_BYTES; i++)
        begin
            host_send(debug_pkg::write_rom, prog[i]);
            model_step(prog[i]);
        end
        host_send(debug_pkg::free_run, 8'h00);
        repeat (RUN_CYCLES) @(posedge clk);
        host_send(debug_pkg::debug, 8'h00);
        repeat (4) @(posedge clk);
        read_registers();
        finish_test();
    endtask

    task automatic dropped_reports();
        begin_test("dropped_reports");
        @(posedge clk);
        send_ready <= 1'b0;
        // nothing queued, so the monitor flags any send_en here
        host_send(debug_pkg::read_b, 8'h00);
        repeat (8) @(posedge clk);
        send_ready <= 1'b1;
        expect_report(debug_pkg::read_b, model_regs[1]);
        host_send(debug_pkg::read_b, 8'h00);
        wait_responses(20);
        finish_test();
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial
    begin
        seed         = 32'hca57d81b;
        cur_test     = "reset";
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < debug_pkg::REG_COUNT; r++)
            model_regs[r] = 8'h00;
        rst_n      <= 1'b0;
        recv_en    <= 1'b0;
        // debug level across reset parks the cpu right away
        recv_cmd   <= debug_pkg::debug;
        recv_data  <= 8'h00;
        send_ready <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        debug_stepping();
        rom_round_trip();
        clear_data_fill();
        free_run_program();
        dropped_reports();
        repeat (4) @(posedge clk);
        total_errors = error_count + uut.u_decode.u_assertions.fail_count;
        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* debug_system.f */
source/debug_pkg.sv
source/debug_cmd_decode.sv
source/program_rom.sv
source/cpu_execute.sv
source/reg_report.sv
source/debug_system.sv
tb/debug_system_assertions.sv
tb/debug_system_tb.sv

/* Makefile */
# Verilator build and run for the debug subsystem testbench

VERILATOR ?= verilator
TOP       ?= debug_system_tb
FILELIST  ?= debug_system.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
